//--- dv/ctrlChecker.sv
`timescale 1ns/1ps
`default_nettype none

module ctrlChecker (
    input  logic              clk,
    input  logic              reset,
    input  ctrlPkg::ctrlWordT ctrl,
    input  logic              expActive,
    input  int                expIndex,
    input  int                expLen,
    input  int                expPcWrites,
    input  logic [3:0]        expSeen,   // regWrite, memWrite, hiloWrite, epcWrite
    input  logic [2:0]        expVector,
    output int                errorCount,
    output int                checkCount
);

    int         len;
    int         pcWrites;
    int         otherEnables;
    logic [3:0] seen;
    logic [2:0] vector;
    logic       prevEpc;
    logic       measuring;
    logic       started; // first irWrite after reset seen
    int         refIndex;
    int         refLen;
    int         refPcWrites;
    logic [3:0] refSeen;
    logic [2:0] refVector;

    task automatic compare(input string what, input int got, input int want);
        checkCount++;
        if (got != want) begin
            errorCount++;
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    task automatic clearCounts();
        len          = 0;
        pcWrites     = 0;
        otherEnables = 0;
        seen         = '0;
        vector       = '0;
        prevEpc      = 1'b0;
    endtask

    task automatic closeRecord();
        compare($sformatf("record %0d length", refIndex), len, refLen);
        compare($sformatf("record %0d pcWrite cycles", refIndex), pcWrites, refPcWrites);
        compare($sformatf("record %0d write flags", refIndex), seen, refSeen);
        compare($sformatf("record %0d vector iorD", refIndex), vector, refVector);
    endtask

    initial begin
        errorCount = 0;
        checkCount = 0;
        started    = 1'b0;
        measuring  = 1'b0;
        clearCounts();
    end

    // sampled mid-cycle when ctrl and expected values have settled
    always @(negedge clk) begin
        if (reset) begin
            clearCounts();
            started   = 1'b0;
            measuring = 1'b0;
        end else begin
            if (ctrl.irWrite) begin
                if (!started) begin
                    compare("cycles before first irWrite", len, 2);
                    compare("pcWrite cycles before first irWrite", pcWrites, 1);
                    compare("other enable cycles before first irWrite", otherEnables, 0);
                    started = 1'b1;
                end
                if (measuring) begin
                    closeRecord();
                end
                measuring   = expActive;
                refIndex    = expIndex;
                refLen      = expLen;
                refPcWrites = expPcWrites;
                refSeen     = expSeen;
                refVector   = expVector;
                clearCounts();
            end
            len++;
            if (ctrl.pcWrite) begin
                pcWrites++;
            end
            if (ctrl.memWrite || ctrl.regWrite || ctrl.abWrite || ctrl.hiloWrite
                    || ctrl.aluOutWrite || ctrl.epcWrite || ctrl.multStart || ctrl.divStart) begin
                otherEnables++;
            end
            seen = seen | {ctrl.regWrite, ctrl.memWrite, ctrl.hiloWrite, ctrl.epcWrite};
            if (prevEpc) begin
                vector = ctrl.iorD; // vector select follows the EPC save
            end
            prevEpc = ctrl.epcWrite;
        end
    end

endmodule

`default_nettype wire

//--- dv/ctrlUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module ctrlUnitTb;

    typedef struct {
        ctrlPkg::opcodeT opcode;
        ctrlPkg::functT  funct;
        ctrlPkg::flagsT  flags;
        int              stopDelay; // -1 when no stop flag is raised
        int              len;
        int              pcWrites;
        logic [3:0]      seen;      // regWrite, memWrite, hiloWrite, epcWrite
        logic [2:0]      vector;
    } instrRecT;

    logic              clk;
    logic              reset;
    ctrlPkg::flagsT    flags;
    ctrlPkg::opcodeT   opcode;
    ctrlPkg::functT    funct;
    ctrlPkg::ctrlWordT ctrl;

    logic        expActive;
    int          expIndex;
    int          expLen;
    int          expPcWrites;
    logic [3:0]  expSeen;
    logic [2:0]  expVector;
    int          errorCount;
    int          checkCount;
    int          cycleLimit = 0;
    int          cycles;
    logic [31:0] rngState;
    instrRecT    records[$];

    tbClockGen clockGen (.clk(clk), .reset(reset));

    ctrlUnit dut (
        .clk    (clk),
        .reset  (reset),
        .flags  (flags),
        .opcode (opcode),
        .funct  (funct),
        .ctrl   (ctrl)
    );

    ctrlChecker monitor (
        .clk         (clk),
        .reset       (reset),
        .ctrl        (ctrl),
        .expActive   (expActive),
        .expIndex    (expIndex),
        .expLen      (expLen),
        .expPcWrites (expPcWrites),
        .expSeen     (expSeen),
        .expVector   (expVector),
        .errorCount  (errorCount),
        .checkCount  (checkCount)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int randomDelay();
        rngState = xorshift(rngState);
        return int'(rngState % 32'd6); // 0 to 5 cycles
    endfunction

    function automatic ctrlPkg::flagsT makeFlags(input logic overflow, input logic et,
                                                 input logic gt, input logic divZero);
        ctrlPkg::flagsT f;
        f          = '0;
        f.overflow = overflow;
        f.et       = et;
        f.gt       = gt;
        f.divZero  = divZero;
        return f;
    endfunction

    task automatic addRecord(input ctrlPkg::opcodeT op, input ctrlPkg::functT fn,
                             input ctrlPkg::flagsT f, input int stop, input int len,
                             input int pcWrites, input logic [3:0] seen,
                             input logic [2:0] vector);
        instrRecT r;
        r.opcode    = op;
        r.funct     = fn;
        r.flags     = f;
        r.stopDelay = stop;
        r.len       = len;
        r.pcWrites  = pcWrites;
        r.seen      = seen;
        r.vector    = vector;
        records.push_back(r);
    endtask

    task automatic buildTable();
        ctrlPkg::flagsT clear;
        ctrlPkg::flagsT ovf;
        int             d;
        clear = makeFlags(1'b0, 1'b0, 1'b0, 1'b0);
        ovf   = makeFlags(1'b1, 1'b0, 1'b0, 1'b0);
        addRecord(ctrlPkg::opRType, ctrlPkg::fnAdd, clear, -1, 8, 1, 4'b1000, 3'd0);
        addRecord(ctrlPkg::opRType, ctrlPkg::fnSub, clear, -1, 8, 1, 4'b1000, 3'd0);
        addRecord(ctrlPkg::opRType, ctrlPkg::fnAnd, clear, -1, 8, 1, 4'b1000, 3'd0);
        addRecord(ctrlPkg::opRType, ctrlPkg::fnSlt, clear, -1, 7, 1, 4'b1000, 3'd0);
        addRecord(ctrlPkg::opAddi, 6'h00, clear, -1, 8, 1, 4'b1000, 3'd0);
        addRecord(ctrlPkg::opAddiu, 6'h00, clear, -1, 8, 1, 4'b1000, 3'd0);
        addRecord(ctrlPkg::opJ, 6'h00, clear, -1, 7, 2, 4'b0000, 3'd0);
        addRecord(ctrlPkg::opRType, ctrlPkg::fnJr, clear, -1, 7, 2, 4'b0000, 3'd0);
        addRecord(ctrlPkg::opRType, ctrlPkg::fnMfhi, clear, -1, 7, 1, 4'b1000, 3'd0);
        addRecord(ctrlPkg::opRType, ctrlPkg::fnMflo, clear, -1, 7, 1, 4'b1000, 3'd0);
        // taken branches write pc twice
        addRecord(ctrlPkg::opBeq, 6'h00, makeFlags(0, 1, 0, 0), -1, 8, 2, 4'b0000, 3'd0);
        addRecord(ctrlPkg::opBeq, 6'h00, makeFlags(0, 0, 1, 0), -1, 8, 1, 4'b0000, 3'd0);
        addRecord(ctrlPkg::opBne, 6'h00, makeFlags(0, 0, 0, 0), -1, 8, 2, 4'b0000, 3'd0);
        addRecord(ctrlPkg::opBne, 6'h00, makeFlags(0, 1, 0, 0), -1, 8, 1, 4'b0000, 3'd0);
        addRecord(ctrlPkg::opBle, 6'h00, makeFlags(0, 0, 0, 0), -1, 8, 2, 4'b0000, 3'd0);
        addRecord(ctrlPkg::opBle, 6'h00, makeFlags(0, 0, 1, 0), -1, 8, 1, 4'b0000, 3'd0);
        addRecord(ctrlPkg::opBgt, 6'h00, makeFlags(0, 0, 1, 0), -1, 8, 2, 4'b0000, 3'd0);
        addRecord(ctrlPkg::opBgt, 6'h00, makeFlags(0, 1, 0, 0), -1, 8, 1, 4'b0000, 3'd0);
        addRecord(ctrlPkg::opLw, 6'h00, clear, -1, 10, 1, 4'b1000, 3'd0);
        addRecord(ctrlPkg::opSw, 6'h00, clear, -1, 11, 1, 4'b0100, 3'd0);
        for (int i = 0; i < 2; i++) begin
            d = randomDelay();
            addRecord(ctrlPkg::opRType, ctrlPkg::fnMult, clear, d, 9 + d, 1, 4'b0010, 3'd0);
            d = randomDelay();
            addRecord(ctrlPkg::opRType, ctrlPkg::fnDiv, clear, d, 9 + d, 1, 4'b0010, 3'd0);
        end
        // pc written by fetch and by the handler jump in every exception
        addRecord(ctrlPkg::opRType, ctrlPkg::fnDiv, makeFlags(0, 0, 0, 1), -1, 12, 2,
                  4'b0001, 3'd5);
        addRecord(6'h3f, 6'h00, clear, -1, 12, 2, 4'b0001, 3'd3);
        addRecord(ctrlPkg::opRType, 6'h3f, clear, -1, 12, 2, 4'b0001, 3'd3);
        addRecord(ctrlPkg::opRType, ctrlPkg::fnAdd, ovf, -1, 12, 2, 4'b0001, 3'd4);
        addRecord(ctrlPkg::opRType, ctrlPkg::fnSub, ovf, -1, 12, 2, 4'b0001, 3'd4);
        addRecord(ctrlPkg::opAddi, 6'h00, ovf, -1, 12, 2, 4'b0001, 3'd4);
        addRecord(ctrlPkg::opAddiu, 6'h00, ovf, -1, 8, 1, 4'b1000, 3'd0); // no trap
        addRecord(ctrlPkg::opRType, ctrlPkg::fnAnd, ovf, -1, 8, 1, 4'b1000, 3'd0);
    endtask

    task automatic waitForIrWrite();
        do begin
            @(posedge clk);
            #1;
        end while (!ctrl.irWrite);
    endtask

    // stop flag goes high stopDelay cycles into the wait
    task automatic raiseStop(input instrRecT r);
        do begin
            @(posedge clk);
            #1;
        end while (!(ctrl.multStart || ctrl.divStart));
        repeat (r.stopDelay) begin
            @(posedge clk);
            #1;
        end
        if (r.funct == ctrlPkg::fnMult) begin
            flags.multStop = 1'b1;
        end else begin
            flags.divStop = 1'b1;
        end
    endtask

    initial begin
        instrRecT r;
        int       limit;
        int       total;
        flags       = '0;
        opcode      = '0;
        funct       = '0;
        expActive   = 1'b0;
        expIndex    = 0;
        expLen      = 0;
        expPcWrites = 0;
        expSeen     = '0;
        expVector   = '0;
        rngState    = 32'd65;
        buildTable();
        limit = 8;
        foreach (records[i]) begin
            limit += records[i].len + 6;
        end
        cycleLimit = 2 * limit;
        for (int i = 0; i < records.size(); i++) begin
            r = records[i];
            waitForIrWrite();
            opcode      = r.opcode;
            funct       = r.funct;
            flags       = r.flags;
            expActive   = 1'b1;
            expIndex    = i;
            expLen      = r.len;
            expPcWrites = r.pcWrites;
            expSeen     = r.seen;
            expVector   = r.vector;
            if (r.stopDelay >= 0) begin
                raiseStop(r);
            end
        end
        waitForIrWrite(); // closes the last instruction
        expActive = 1'b0;
        @(negedge clk);
        #1;
        total = errorCount + dut.asserts.failCount;
        $display("Summary: %0d checks, %0d mismatches, %0d assertion failures",
                 checkCount, errorCount, dut.asserts.failCount);
        if (total == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        wait (cycleLimit > 0);
        while (cycles < cycleLimit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", cycleLimit);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/ctrlUnit_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module ctrlUnitAsserts (
    input logic              clk,
    input logic              reset,
    input ctrlPkg::ctrlWordT ctrl
);

    int         failCount = 0;
    logic [9:0] enables;

    assign enables = {ctrl.memWrite, ctrl.pcWrite, ctrl.irWrite, ctrl.regWrite, ctrl.abWrite,
                      ctrl.hiloWrite, ctrl.aluOutWrite, ctrl.epcWrite, ctrl.multStart,
                      ctrl.divStart};

    pcMemExclusive: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.pcWrite && ctrl.memWrite))
    else begin
        failCount++;
        $error("pcWrite and memWrite are high in the same cycle");
    end

    irWriteSingle: assert property (@(posedge clk) disable iff (reset)
        ctrl.irWrite |=> !ctrl.irWrite)
    else begin
        failCount++;
        $error("irWrite stayed high for two cycles");
    end

    // handler fetch must follow the EPC save
    epcThenFetch: assert property (@(posedge clk) disable iff (reset)
        ctrl.epcWrite |-> ##[1:12] ctrl.irWrite)
    else begin
        failCount++;
        $error("no irWrite within 12 cycles after epcWrite");
    end

    quietAfterReset: assert property (@(posedge clk) $fell(reset) |-> enables == '0)
    else begin
        failCount++;
        $error("an enable is high in the cycle after reset");
    end

endmodule

bind ctrlUnit ctrlUnitAsserts asserts (.clk(clk), .reset(reset), .ctrl(ctrl));

`default_nettype wire

//--- dv/tbClockGen.sv
`timescale 1ns/1ps
`default_nettype none

module tbClockGen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- hdl/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

    typedef logic [5:0] opcodeT;
    typedef logic [5:0] functT;
    typedef logic [2:0] aluOpT;
    typedef logic [1:0] loadSizeT;

    // instruction opcodes
    localparam opcodeT opRType = 6'h00;
    localparam opcodeT opJ     = 6'h02;
    localparam opcodeT opBeq   = 6'h04;
    localparam opcodeT opBne   = 6'h05;
    localparam opcodeT opBle   = 6'h06;
    localparam opcodeT opBgt   = 6'h07;
    localparam opcodeT opAddi  = 6'h08;
    localparam opcodeT opAddiu = 6'h09;
    localparam opcodeT opLw    = 6'h23;
    localparam opcodeT opSw    = 6'h2b;

    // R-format function codes
    localparam functT fnJr   = 6'h08;
    localparam functT fnMfhi = 6'h10;
    localparam functT fnMflo = 6'h12;
    localparam functT fnMult = 6'h18;
    localparam functT fnDiv  = 6'h1a;
    localparam functT fnAdd  = 6'h20;
    localparam functT fnSub  = 6'h22;
    localparam functT fnAnd  = 6'h24;
    localparam functT fnSlt  = 6'h2a;

    localparam aluOpT aluPass = 3'd0; // A straight through
    localparam aluOpT aluAdd  = 3'd1;
    localparam aluOpT aluSub  = 3'd2;
    localparam aluOpT aluAnd  = 3'd3;
    localparam aluOpT aluCmp  = 3'd7; // sets et/gt/lt

    localparam loadSizeT loadWord = 2'd1;
    localparam loadSizeT loadByte = 2'd3;

    typedef enum logic [3:0] {
        clsAluRd, clsAluRt, clsSlt, clsJr, clsJump,
        clsBeq, clsBne, clsBle, clsBgt,
        clsLoad, clsStore, clsMult, clsDiv, clsMfhi, clsMflo,
        clsIllegal
    } instrClassT;

    typedef enum logic [6:0] {
        fetch1, fetch2, fetch3, decode1, decode2, execute,
        aluToRd, aluToRt, branchResolve,
        load1, load2, load3, store1, store2, store3, store4,
        multWait, multDone, divWait, divDone,
        exc1, exc2, excWait1, excWait2, excWait3, done
    } ctrlStateT;

    typedef enum logic [1:0] {
        excNone, excIllegal, excOverflow, excDivZero
    } excCauseT;

    typedef struct packed {
        logic overflow;
        logic et;
        logic gt;
        logic lt;
        logic multStop;
        logic divStop;
        logic divZero;
    } flagsT;

    typedef struct packed {
        logic       memWrite;
        logic       pcWrite;
        logic       irWrite;
        logic       regWrite;
        logic       abWrite;
        logic       hiloWrite;
        logic       aluOutWrite;
        logic       epcWrite;
        aluOpT      aluOp;
        logic       multStart;
        logic       divStart;
        loadSizeT   loadSize;
        logic [2:0] regDst;
        logic [3:0] memToReg;
        logic [2:0] pcSource;
        logic [1:0] aluSrcA;
        logic [1:0] aluSrcB;
        logic       hiloSelect;
        logic [2:0] iorD;
    } ctrlWordT;

endpackage

`default_nettype wire

//--- hdl/ctrlSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module ctrlSequencer (
    input  logic                clk,
    input  logic                reset,
    input  ctrlPkg::instrClassT instrClass,
    input  logic                overflowTrap,
    input  ctrlPkg::flagsT      flags,
    output ctrlPkg::ctrlStateT  nextState,
    output ctrlPkg::excCauseT   excCause
);

    ctrlPkg::ctrlStateT state;
    ctrlPkg::excCauseT  excNext;
    logic               aluTrap;

    // ALU result is on the flags during execute, before any write-back
    assign aluTrap = flags.overflow && overflowTrap;

    always_comb begin
        nextState = state; // waits hold here
        excNext   = ctrlPkg::excNone;
        case (state)
            ctrlPkg::fetch1:  nextState = ctrlPkg::fetch2;
            ctrlPkg::fetch2:  nextState = ctrlPkg::fetch3;
            ctrlPkg::fetch3:  nextState = ctrlPkg::decode1;
            ctrlPkg::decode1: nextState = ctrlPkg::decode2;
            ctrlPkg::decode2: nextState = ctrlPkg::execute;
            ctrlPkg::execute: begin
                case (instrClass)
                    ctrlPkg::clsAluRd: begin
                        nextState = aluTrap ? ctrlPkg::exc1 : ctrlPkg::aluToRd;
                        excNext   = ctrlPkg::excOverflow;
                    end
                    ctrlPkg::clsAluRt: begin
                        nextState = aluTrap ? ctrlPkg::exc1 : ctrlPkg::aluToRt;
                        excNext   = ctrlPkg::excOverflow;
                    end
                    ctrlPkg::clsSlt, ctrlPkg::clsJr, ctrlPkg::clsJump,
                    ctrlPkg::clsMfhi, ctrlPkg::clsMflo: begin
                        nextState = ctrlPkg::done; // single-step instructions
                    end
                    ctrlPkg::clsBeq, ctrlPkg::clsBne,
                    ctrlPkg::clsBle, ctrlPkg::clsBgt: begin
                        nextState = ctrlPkg::branchResolve;
                    end
                    ctrlPkg::clsLoad:  nextState = ctrlPkg::load1;
                    ctrlPkg::clsStore: nextState = ctrlPkg::store1;
                    ctrlPkg::clsMult:  nextState = ctrlPkg::multWait;
                    ctrlPkg::clsDiv:   nextState = ctrlPkg::divWait;
                    default: begin
                        nextState = ctrlPkg::exc1;
                        excNext   = ctrlPkg::excIllegal;
                    end
                endcase
            end
            ctrlPkg::load1:  nextState = ctrlPkg::load2;
            ctrlPkg::load2:  nextState = ctrlPkg::load3;
            ctrlPkg::store1: nextState = ctrlPkg::store2;
            ctrlPkg::store2: nextState = ctrlPkg::store3;
            ctrlPkg::store3: nextState = ctrlPkg::store4;
            ctrlPkg::multWait: begin
                if (flags.multStop) begin
                    nextState = ctrlPkg::multDone;
                end
            end
            ctrlPkg::divWait: begin
                if (flags.divZero) begin
                    nextState = ctrlPkg::exc1;
                    excNext   = ctrlPkg::excDivZero;
                end else if (flags.divStop) begin
                    nextState = ctrlPkg::divDone;
                end
            end
            ctrlPkg::exc1: nextState = ctrlPkg::exc2;
            ctrlPkg::exc2: begin
                // the divide path already spent a cycle in divWait
                if (excCause == ctrlPkg::excDivZero) begin
                    nextState = ctrlPkg::excWait2;
                end else begin
                    nextState = ctrlPkg::excWait1;
                end
            end
            ctrlPkg::excWait1: nextState = ctrlPkg::excWait2;
            ctrlPkg::excWait2: nextState = ctrlPkg::excWait3;
            ctrlPkg::aluToRd, ctrlPkg::aluToRt, ctrlPkg::branchResolve,
            ctrlPkg::load3, ctrlPkg::store4, ctrlPkg::multDone,
            ctrlPkg::divDone, ctrlPkg::excWait3: begin
                nextState = ctrlPkg::done;
            end
            default: nextState = ctrlPkg::fetch1; // done and unused codes
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ctrlPkg::fetch1;
            excCause <= ctrlPkg::excNone;
        end else begin
            state <= nextState;
            if (nextState == ctrlPkg::done) begin
                excCause <= ctrlPkg::excNone;
            end else if (nextState == ctrlPkg::exc1) begin
                excCause <= excNext; // latched on the way into exc1
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/ctrlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module ctrlUnit (
    input  logic              clk,
    input  logic              reset,
    input  ctrlPkg::flagsT    flags,
    input  ctrlPkg::opcodeT   opcode,
    input  ctrlPkg::functT    funct,
    output ctrlPkg::ctrlWordT ctrl
);

    ctrlPkg::instrClassT instrClass;
    ctrlPkg::aluOpT      aluOp;
    logic                overflowTrap;
    ctrlPkg::ctrlStateT  nextState;
    ctrlPkg::excCauseT   excCause;

    instrDecoder decoder (
        .opcode       (opcode),
        .funct        (funct),
        .instrClass   (instrClass),
        .aluOp        (aluOp),
        .overflowTrap (overflowTrap)
    );

    ctrlSequencer sequencer (
        .clk          (clk),
        .reset        (reset),
        .instrClass   (instrClass),
        .overflowTrap (overflowTrap),
        .flags        (flags),
        .nextState    (nextState),
        .excCause     (excCause)
    );

    // word register advances on the same edge as the state register
    ctrlWordGen wordGen (
        .clk        (clk),
        .reset      (reset),
        .nextState  (nextState),
        .instrClass (instrClass),
        .aluOp      (aluOp),
        .excCause   (excCause),
        .flags      (flags),
        .ctrl       (ctrl)
    );

endmodule

`default_nettype wire

//--- hdl/ctrlWordGen.sv
`timescale 1ns/1ps
`default_nettype none

module ctrlWordGen (
    input  logic                clk,
    input  logic                reset,
    input  ctrlPkg::ctrlStateT  nextState,
    input  ctrlPkg::instrClassT instrClass,
    input  ctrlPkg::aluOpT      aluOp,
    input  ctrlPkg::excCauseT   excCause,
    input  ctrlPkg::flagsT      flags,
    output ctrlPkg::ctrlWordT   ctrl
);

    ctrlPkg::ctrlStateT curState; // state the current word belongs to
    ctrlPkg::ctrlWordT  word;
    logic               taken;
    logic [2:0]         vectorSel;

    always_comb begin
        case (instrClass)
            ctrlPkg::clsBeq: taken = flags.et;
            ctrlPkg::clsBne: taken = !flags.et;
            ctrlPkg::clsBle: taken = !flags.gt;
            ctrlPkg::clsBgt: taken = flags.gt;
            default:         taken = 1'b0;
        endcase
    end

    always_comb begin
        case (excCause)
            ctrlPkg::excIllegal:  vectorSel = 3'd3;
            ctrlPkg::excOverflow: vectorSel = 3'd4;
            ctrlPkg::excDivZero:  vectorSel = 3'd5;
            default:              vectorSel = 3'd0;
        endcase
    end

    always_comb begin
        word = ctrl; // unassigned fields hold
        case (nextState)
            ctrlPkg::fetch1: begin
                word.iorD     = 3'd0; // read at pc
                word.memWrite = 1'b0;
            end
            ctrlPkg::fetch2: begin
                word.aluSrcA  = 2'd0;
                word.aluSrcB  = 2'd1; // pc + 4
                word.aluOp    = ctrlPkg::aluAdd;
                word.pcSource = 3'd1;
                word.pcWrite  = 1'b1;
            end
            ctrlPkg::fetch3: begin
                word.pcWrite = 1'b0;
                word.irWrite = 1'b1;
            end
            ctrlPkg::decode1: begin
                word.irWrite     = 1'b0;
                word.aluSrcA     = 2'd0;
                word.aluSrcB     = 2'd3; // branch target
                word.aluOp       = ctrlPkg::aluAdd;
                word.aluOutWrite = 1'b1;
            end
            ctrlPkg::decode2: begin
                word.abWrite     = 1'b1;
                word.aluOutWrite = 1'b0;
            end
            ctrlPkg::execute: begin
                word.abWrite = 1'b0;
                word.aluOp   = aluOp;
                word.aluSrcA = 2'd1;
                case (instrClass)
                    ctrlPkg::clsAluRd: begin
                        word.aluSrcB     = 2'd0;
                        word.aluOutWrite = 1'b1;
                    end
                    ctrlPkg::clsAluRt, ctrlPkg::clsLoad, ctrlPkg::clsStore: begin
                        word.aluSrcB     = 2'd2; // sign-extended immediate
                        word.aluOutWrite = 1'b1;
                    end
                    ctrlPkg::clsSlt: begin
                        word.aluSrcB  = 2'd0;
                        word.regDst   = 3'd1;
                        word.memToReg = 4'd4;
                        word.regWrite = 1'b1;
                    end
                    ctrlPkg::clsJr: begin
                        word.pcSource = 3'd1;
                        word.pcWrite  = 1'b1;
                    end
                    ctrlPkg::clsJump: begin
                        word.pcSource = 3'd3;
                        word.pcWrite  = 1'b1;
                    end
                    ctrlPkg::clsBeq, ctrlPkg::clsBne,
                    ctrlPkg::clsBle, ctrlPkg::clsBgt: begin
                        word.aluSrcB = 2'd0;
                    end
                    ctrlPkg::clsMfhi, ctrlPkg::clsMflo: begin
                        word.memToReg = (instrClass == ctrlPkg::clsMfhi) ? 4'd2 : 4'd3;
                        word.regDst   = 3'd1;
                        word.regWrite = 1'b1;
                    end
                    default: ;
                endcase
            end
            ctrlPkg::aluToRd, ctrlPkg::aluToRt: begin
                word.aluOutWrite = 1'b0;
                word.regDst      = (nextState == ctrlPkg::aluToRd) ? 3'd1 : 3'd0;
                word.memToReg    = 4'd0;
                word.regWrite    = 1'b1;
            end
            ctrlPkg::branchResolve: begin
                if (taken) begin
                    word.pcSource = 3'd2;
                    word.pcWrite  = 1'b1;
                end
            end
            ctrlPkg::load1, ctrlPkg::store1: begin
                word.aluOutWrite = 1'b0;
                word.iorD        = 3'd2; // address from ALUOut
            end
            ctrlPkg::load3: begin
                word.loadSize = ctrlPkg::loadWord;
                word.memToReg = 4'd1;
                word.regDst   = 3'd0;
                word.regWrite = 1'b1;
            end
            ctrlPkg::store4: word.memWrite = 1'b1;
            // one-cycle start pulse on entry from execute
            ctrlPkg::multWait: word.multStart = (curState == ctrlPkg::execute);
            ctrlPkg::divWait:  word.divStart = (curState == ctrlPkg::execute);
            ctrlPkg::multDone, ctrlPkg::divDone: begin
                word.multStart  = 1'b0;
                word.divStart   = 1'b0;
                word.hiloSelect = (nextState == ctrlPkg::divDone);
                word.hiloWrite  = 1'b1;
            end
            ctrlPkg::exc1: begin
                word.divStart = 1'b0;
                word.aluSrcA  = 2'd0;
                word.aluSrcB  = 2'd1; // pc - 4 into EPC
                word.aluOp    = ctrlPkg::aluSub;
                word.epcWrite = 1'b1;
            end
            ctrlPkg::exc2: begin
                word.epcWrite = 1'b0;
                word.memWrite = 1'b0;
                word.iorD     = vectorSel;
            end
            ctrlPkg::excWait3: begin
                word.loadSize = ctrlPkg::loadByte; // handler address byte
                word.pcSource = 3'd0;
                word.pcWrite  = 1'b1;
            end
            ctrlPkg::done: word = '0;
            default: ; // load2, store2-3, excWait1-2 just wait
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl     <= '0;
            curState <= ctrlPkg::fetch1;
        end else begin
            ctrl     <= word;
            curState <= nextState;
        end
    end

endmodule

`default_nettype wire

//--- hdl/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  ctrlPkg::opcodeT     opcode,
    input  ctrlPkg::functT      funct,
    output ctrlPkg::instrClassT instrClass,
    output ctrlPkg::aluOpT      aluOp,
    output logic                overflowTrap
);

    always_comb begin
        instrClass   = ctrlPkg::clsIllegal; // unknown opcode or funct
        aluOp        = ctrlPkg::aluPass;
        overflowTrap = 1'b0;
        case (opcode)
            ctrlPkg::opRType: begin
                case (funct)
                    ctrlPkg::fnAdd: begin
                        instrClass   = ctrlPkg::clsAluRd;
                        aluOp        = ctrlPkg::aluAdd;
                        overflowTrap = 1'b1;
                    end
                    ctrlPkg::fnSub: begin
                        instrClass   = ctrlPkg::clsAluRd;
                        aluOp        = ctrlPkg::aluSub;
                        overflowTrap = 1'b1;
                    end
                    ctrlPkg::fnAnd: begin
                        instrClass = ctrlPkg::clsAluRd;
                        aluOp      = ctrlPkg::aluAnd;
                    end
                    ctrlPkg::fnSlt: begin
                        instrClass = ctrlPkg::clsSlt;
                        aluOp      = ctrlPkg::aluCmp;
                    end
                    ctrlPkg::fnJr:   instrClass = ctrlPkg::clsJr; // pass rs to pc
                    ctrlPkg::fnMult: instrClass = ctrlPkg::clsMult;
                    ctrlPkg::fnDiv:  instrClass = ctrlPkg::clsDiv;
                    ctrlPkg::fnMfhi: instrClass = ctrlPkg::clsMfhi;
                    ctrlPkg::fnMflo: instrClass = ctrlPkg::clsMflo;
                    default: ;
                endcase
            end
            ctrlPkg::opAddi: begin
                instrClass   = ctrlPkg::clsAluRt;
                aluOp        = ctrlPkg::aluAdd;
                overflowTrap = 1'b1;
            end
            ctrlPkg::opAddiu: begin
                instrClass = ctrlPkg::clsAluRt; // unsigned add never traps
                aluOp      = ctrlPkg::aluAdd;
            end
            ctrlPkg::opBeq: begin
                instrClass = ctrlPkg::clsBeq;
                aluOp      = ctrlPkg::aluCmp;
            end
            ctrlPkg::opBne: begin
                instrClass = ctrlPkg::clsBne;
                aluOp      = ctrlPkg::aluCmp;
            end
            ctrlPkg::opBle: begin
                instrClass = ctrlPkg::clsBle;
                aluOp      = ctrlPkg::aluCmp;
            end
            ctrlPkg::opBgt: begin
                instrClass = ctrlPkg::clsBgt;
                aluOp      = ctrlPkg::aluCmp;
            end
            ctrlPkg::opLw: begin
                instrClass = ctrlPkg::clsLoad;
                aluOp      = ctrlPkg::aluAdd; // base + offset
            end
            ctrlPkg::opSw: begin
                instrClass = ctrlPkg::clsStore;
                aluOp      = ctrlPkg::aluAdd;
            end
            ctrlPkg::opJ: instrClass = ctrlPkg::clsJump;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- src.f
hdl/ctrlPkg.sv
hdl/instrDecoder.sv
hdl/ctrlSequencer.sv
hdl/ctrlWordGen.sv
hdl/ctrlUnit.sv
dv/ctrlUnit_asserts.sv
dv/tbClockGen.sv
dv/ctrlChecker.sv
dv/ctrlUnitTb.sv
